//--- execute_stage.f
+incdir+src
src/exec_pkg.sv
src/alu.sv
src/muldiv_unit.sv
src/execute_stage.sv
verification/execute_stage_props.sv
verification/execute_stage_tb.sv

//--- src/alu.sv
`include "exec_defs.svh"

module alu
    import exec_pkg::*;
(
    input  alu_sel_e          i_exe,
    input  br_sel_e           i_br_exe,
    input  sign_sel_e         i_sign_sel,
    input  logic [`XLEN-1:0]  i_op1,
    input  logic [`XLEN-1:0]  i_op2,
    output logic [`XLEN-1:0]  o_alu_out,
    output logic              o_branch_take
);

    logic                       is_signed;
    logic                       op_lt;
    logic [`SHAMT_W-1:0]        shamt;
    logic signed [`XLEN-1:0]    sra_res;

    assign is_signed = (i_sign_sel == OP_SIGNED);
    assign shamt     = i_op2[`SHAMT_W-1:0];
    assign sra_res   = $signed(i_op1) >>> shamt;

    // Shared by SLT and the LT/GE branches
    always_comb begin
        if (is_signed) begin
            op_lt = ($signed(i_op1) < $signed(i_op2));
        end else begin
            op_lt = (i_op1 < i_op2);
        end
    end

    always_comb begin
        case (i_exe)
            ALU_ADD:   o_alu_out = i_op1 + i_op2;
            ALU_SUB:   o_alu_out = i_op1 - i_op2;
            ALU_AND:   o_alu_out = i_op1 & i_op2;
            ALU_OR:    o_alu_out = i_op1 | i_op2;
            ALU_XOR:   o_alu_out = i_op1 ^ i_op2;
            ALU_SLL:   o_alu_out = i_op1 << shamt;
            ALU_SRL:   o_alu_out = i_op1 >> shamt;
            ALU_SRA:   o_alu_out = sra_res;
            ALU_SLT:   o_alu_out = {{(`XLEN-1){1'b0}}, op_lt};
            ALU_COPY2: o_alu_out = i_op2;
            // Handled by the multiply/divide unit
            ALU_MUL,
            ALU_MULH,
            ALU_MULHSU,
            ALU_DIV,
            ALU_REM:   o_alu_out = '0;
            default:   o_alu_out = '0;
        endcase
    end

    // Branch condition on the same operands
    always_comb begin
        case (i_br_exe)
            BR_EQ:   o_branch_take = (i_op1 == i_op2);
            BR_NE:   o_branch_take = (i_op1 != i_op2);
            BR_LT:   o_branch_take = op_lt;
            BR_GE:   o_branch_take = !op_lt;
            BR_NONE: o_branch_take = 1'b0;
            default: o_branch_take = 1'b0;
        endcase
    end

endmodule

//--- src/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath and address width
`define XLEN        32

// One multiply/divide iteration per operand bit
`define MD_CYCLES   `XLEN

// Field widths of the execute control word
`define ALU_SEL_W   4
`define BR_SEL_W    3

// Shift amount taken from the low bits of op2
`define SHAMT_W     5

`endif

//--- src/exec_pkg.sv
`include "exec_defs.svh"

package exec_pkg;

    // ALU and multiply/divide operation selector
    typedef enum logic [`ALU_SEL_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_COPY2  = 4'd9,   // Pass op2 through (LUI style)
        ALU_MUL    = 4'd10,
        ALU_MULH   = 4'd11,
        ALU_MULHSU = 4'd12,
        ALU_DIV    = 4'd13,
        ALU_REM    = 4'd14
    } alu_sel_e;

    // Conditional branch kinds
    typedef enum logic [`BR_SEL_W-1:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } br_sel_e;

    typedef enum logic {
        OP_SIGNED   = 1'b0,
        OP_UNSIGNED = 1'b1
    } sign_sel_e;

    // Control word from decode
    typedef struct packed {
        alu_sel_e  i_exe;
        br_sel_e   br_exe;
        sign_sel_e sign_sel;
        logic      jmp_pc_flg;    // JAL
        logic      jmp_reg_flg;   // JALR
    } exec_ctrl_t;

    // Request toward the multiply/divide unit, ready comes back separately
    typedef struct packed {
        logic              valid;
        alu_sel_e          sel;
        logic              is_signed;
        logic [`XLEN-1:0]  op1;
        logic [`XLEN-1:0]  op2;
    } muldiv_req_t;

    typedef struct packed {
        logic              valid;    // One cycle strobe
        logic [`XLEN-1:0]  result;
    } muldiv_resp_t;

endpackage

//--- src/execute_stage.sv
`include "exec_defs.svh"

module execute_stage
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_flush,
    input  logic              i_valid,
    input  logic              i_is_new,
    input  logic [`XLEN-1:0]  i_pc,
    input  exec_ctrl_t        i_ctrl,
    input  logic [`XLEN-1:0]  i_imm_b,
    input  logic [`XLEN-1:0]  i_imm_j,
    input  logic [`XLEN-1:0]  i_op1,
    input  logic [`XLEN-1:0]  i_op2,

    output logic [`XLEN-1:0]  o_next_alu_out,
    output logic              o_branch_taken,
    output logic [`XLEN-1:0]  o_branch_target,
    output logic              o_is_stall
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,   // Unit still busy, possibly with a flushed op
        WAIT_CALC
    } stage_state_e;

    stage_state_e         state;
    logic                 is_muldiv;
    logic [`XLEN-1:0]     alu_out;
    logic                 alu_branch_take;
    logic [`XLEN-1:0]     saved_result;
    logic [`XLEN-1:0]     target_sum;

    muldiv_req_t          md_req;
    muldiv_resp_t         md_resp;
    logic                 md_ready;

    alu u_alu (
        .i_exe         (i_ctrl.i_exe),
        .i_br_exe      (i_ctrl.br_exe),
        .i_sign_sel    (i_ctrl.sign_sel),
        .i_op1         (i_op1),
        .i_op2         (i_op2),
        .o_alu_out     (alu_out),
        .o_branch_take (alu_branch_take)
    );

    muldiv_unit u_muldiv_unit (
        .clk     (clk),
        .i_reset (i_reset),
        .i_req   (md_req),
        .o_ready (md_ready),
        .o_resp  (md_resp)
    );

    assign is_muldiv = (i_ctrl.i_exe == ALU_MUL)    | (i_ctrl.i_exe == ALU_MULH) |
                       (i_ctrl.i_exe == ALU_MULHSU) | (i_ctrl.i_exe == ALU_DIV)  |
                       (i_ctrl.i_exe == ALU_REM);

    // Request stays up from a new op until the unit takes it
    assign md_req.valid     = i_valid & ((i_is_new & (state == IDLE) & is_muldiv)
                                         | (state == WAIT_READY));
    assign md_req.sel       = i_ctrl.i_exe;
    assign md_req.is_signed = (i_ctrl.sign_sel == OP_SIGNED);
    assign md_req.op1       = i_op1;
    assign md_req.op2       = i_op2;

    assign o_is_stall = i_valid & ((i_is_new & (state == IDLE) & is_muldiv)
                                   | (state == WAIT_READY)
                                   | ((state == WAIT_CALC) & !md_resp.valid));

    always_comb begin
        if (state == WAIT_CALC) begin
            o_next_alu_out = md_resp.result;
        end else if (is_muldiv) begin
            o_next_alu_out = saved_result;   // Instruction still held
        end else begin
            o_next_alu_out = alu_out;
        end
    end

    // Jump and branch target, bit 0 always cleared
    always_comb begin
        if (i_ctrl.jmp_pc_flg) begin
            target_sum = i_pc + i_imm_j;
        end else if (i_ctrl.jmp_reg_flg) begin
            target_sum = i_op1 + i_op2;
        end else begin
            target_sum = i_pc + i_imm_b;
        end
    end

    assign o_branch_target = {target_sum[`XLEN-1:1], 1'b0};
    assign o_branch_taken  = i_valid & (i_ctrl.jmp_pc_flg | i_ctrl.jmp_reg_flg | alu_branch_take);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else if (i_flush | !i_valid) begin
            state <= IDLE;   // A running op is left to finish on its own
        end else begin
            case (state)
                IDLE: if (i_is_new & is_muldiv) begin
                    state <= md_ready ? WAIT_CALC : WAIT_READY;
                end
                WAIT_READY: if (md_ready) state <= WAIT_CALC;
                WAIT_CALC:  if (md_resp.valid) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == WAIT_CALC) & md_resp.valid) begin
            saved_result <= md_resp.result;
        end
    end

endmodule

//--- src/muldiv_unit.sv
`include "exec_defs.svh"

module muldiv_unit
    import exec_pkg::*;
(
    input  logic          clk,
    input  logic          i_reset,
    input  muldiv_req_t   i_req,
    output logic          o_ready,
    output muldiv_resp_t  o_resp
);

    localparam int CNT_W = $clog2(`MD_CYCLES);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MD_CYCLES - 1);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_CALC,
        MD_DONE
    } md_state_e;

    md_state_e            state;
    logic [CNT_W-1:0]     step_cnt;

    // Operation held for the whole run
    alu_sel_e             sel_r;
    logic                 is_div_r;
    logic                 res_neg;
    logic                 special;
    logic [`XLEN-1:0]     special_val;

    // Accumulator/quotient pair and the other operand magnitude
    logic [`XLEN-1:0]     acc;
    logic [`XLEN-1:0]     quo;
    logic [`XLEN-1:0]     opb;

    logic                 accept;
    logic                 req_div;
    logic                 op1_signed;
    logic                 op2_signed;
    logic                 op1_neg;
    logic                 op2_neg;
    logic [`XLEN-1:0]     op1_mag;
    logic [`XLEN-1:0]     op2_mag;
    logic                 div_zero;
    logic                 div_ovf;

    logic [`XLEN:0]       add_a;
    logic [`XLEN:0]       add_b;
    logic [`XLEN:0]       add_sum;
    logic                 add_co;

    logic [2*`XLEN-1:0]   fin_mag;
    logic [2*`XLEN-1:0]   fin_val;

    assign o_ready = (state == MD_IDLE);
    assign accept  = i_req.valid & o_ready;

    assign req_div    = (i_req.sel == ALU_DIV) | (i_req.sel == ALU_REM);
    assign op1_signed = i_req.is_signed | (i_req.sel == ALU_MULHSU);
    assign op2_signed = i_req.is_signed & (i_req.sel != ALU_MULHSU);
    assign op1_neg    = op1_signed & i_req.op1[`XLEN-1];
    assign op2_neg    = op2_signed & i_req.op2[`XLEN-1];
    assign op1_mag    = op1_neg ? -i_req.op1 : i_req.op1;
    assign op2_mag    = op2_neg ? -i_req.op2 : i_req.op2;

    assign div_zero = req_div & (i_req.op2 == '0);
    assign div_ovf  = req_div & i_req.is_signed & (i_req.op2 == '1)
                    & (i_req.op1 == {1'b1, {(`XLEN-1){1'b0}}});

    // One adder, add for multiply and subtract for divide
    assign add_a = is_div_r ? {acc, quo[`XLEN-1]} : {1'b0, acc};
    assign add_b = is_div_r ? ~{1'b0, opb} : {1'b0, opb & {`XLEN{quo[0]}}};
    assign {add_co, add_sum} = {1'b0, add_a} + {1'b0, add_b} + {{(`XLEN+1){1'b0}}, is_div_r};

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= MD_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                MD_IDLE: if (accept) begin
                    state    <= MD_CALC;
                    step_cnt <= '0;
                end
                MD_CALC: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_STEP) state <= MD_DONE;
                end
                MD_DONE: state <= MD_IDLE;
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sel_r    <= i_req.sel;
            is_div_r <= req_div;
            res_neg  <= (i_req.sel == ALU_REM) ? op1_neg : (op1_neg ^ op2_neg);
            special  <= div_zero | div_ovf;
            if (div_zero) begin
                special_val <= (i_req.sel == ALU_DIV) ? '1 : i_req.op1;
            end else begin
                special_val <= (i_req.sel == ALU_DIV) ? i_req.op1 : '0;  // Overflow case
            end
            acc <= '0;
            quo <= op1_mag;
            opb <= op2_mag;
        end else if (state == MD_CALC) begin
            if (is_div_r) begin
                acc <= add_co ? add_sum[`XLEN-1:0] : add_a[`XLEN-1:0];
                quo <= {quo[`XLEN-2:0], add_co};
            end else begin
                acc <= add_sum[`XLEN:1];
                quo <= {add_sum[0], quo[`XLEN-1:1]};
            end
        end
    end

    // Sign correction over the full product or the selected division result
    assign fin_mag = is_div_r ? {{`XLEN{1'b0}}, (sel_r == ALU_REM) ? acc : quo} : {acc, quo};
    assign fin_val = res_neg ? -fin_mag : fin_mag;

    assign o_resp.valid  = (state == MD_DONE);
    assign o_resp.result = special ? special_val :
                           ((sel_r == ALU_MULH) | (sel_r == ALU_MULHSU)) ?
                           fin_val[2*`XLEN-1:`XLEN] : fin_val[`XLEN-1:0];

endmodule

//--- verification/execute_stage_props.sv
`include "exec_defs.svh"

module execute_stage_props
    import exec_pkg::*;
(
    input logic              clk,
    input logic              i_reset,
    input logic              i_valid,
    input logic              i_is_stall,
    input logic [`XLEN-1:0]  i_branch_target,
    input muldiv_req_t       i_md_req,
    input logic              i_md_ready,
    input muldiv_resp_t      i_md_resp
);

    a_stall_needs_valid: assert property (
        @(posedge clk) disable iff (i_reset) i_is_stall |-> i_valid
    ) else $error("o_is_stall high while i_valid is low");

    a_resp_when_busy: assert property (
        @(posedge clk) disable iff (i_reset) i_md_resp.valid |-> !i_md_ready
    ) else $error("multiply/divide response while the unit reports ready");

    // Response exactly MD_CYCLES+1 cycles after the request is taken
    a_resp_latency: assert property (
        @(posedge clk) disable iff (i_reset)
            (i_md_req.valid && i_md_ready) |=>
                (!i_md_resp.valid) [*`MD_CYCLES] ##1 i_md_resp.valid
    ) else $error("multiply/divide response latency wrong");

    a_target_aligned: assert property (
        @(posedge clk) disable iff (i_reset) !i_branch_target[0]
    ) else $error("o_branch_target bit 0 set");

endmodule

bind execute_stage execute_stage_props u_props (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_valid         (i_valid),
    .i_is_stall      (o_is_stall),
    .i_branch_target (o_branch_target),
    .i_md_req        (md_req),
    .i_md_ready      (md_ready),
    .i_md_resp       (md_resp)
);

//--- verification/execute_stage_tb.sv
`include "exec_defs.svh"

module execute_stage_tb
    import exec_pkg::*;
();

    localparam int N_ALU    = 200;
    localparam int N_IDLE   = 40;
    localparam int N_MUL    = 40;
    localparam int N_DIV    = 40;
    localparam int N_FORCED = 8;
    localparam int N_FLUSH  = 10;
    localparam int N_INSTR  = N_ALU + N_IDLE + N_MUL + N_DIV + N_FORCED + 2 * N_FLUSH + 1;
    localparam int WATCHDOG_TIME = N_INSTR * (2 * `MD_CYCLES + 6) * 40;

    logic              clk;
    logic              i_reset;
    logic              i_flush;
    logic              i_valid;
    logic              i_is_new;
    logic [`XLEN-1:0]  i_pc;
    exec_ctrl_t        i_ctrl;
    logic [`XLEN-1:0]  i_imm_b;
    logic [`XLEN-1:0]  i_imm_j;
    logic [`XLEN-1:0]  i_op1;
    logic [`XLEN-1:0]  i_op2;
    logic [`XLEN-1:0]  o_next_alu_out;
    logic              o_branch_taken;
    logic [`XLEN-1:0]  o_branch_target;
    logic              o_is_stall;

    logic [31:0]       rng_state;
    int                checks;
    int                value_errors;
    int                flag_errors;

    execute_stage i_execute_stage (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_flush         (i_flush),
        .i_valid         (i_valid),
        .i_is_new        (i_is_new),
        .i_pc            (i_pc),
        .i_ctrl          (i_ctrl),
        .i_imm_b         (i_imm_b),
        .i_imm_j         (i_imm_j),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .o_next_alu_out  (o_next_alu_out),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_is_stall      (o_is_stall)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Corner values show up often
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 32'h8000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return {28'b0, r[7:4]};
            default: return next_rand();
        endcase
    endfunction

    function automatic exec_ctrl_t random_ctrl(input int n_ops);
        exec_ctrl_t  c;
        logic [31:0] r;
        r = next_rand() % n_ops;
        c.i_exe = alu_sel_e'(r[3:0]);
        r = next_rand() % 5;
        c.br_exe = br_sel_e'(r[2:0]);
        r = next_rand();
        c.sign_sel = r[0] ? OP_UNSIGNED : OP_SIGNED;
        c.jmp_pc_flg = (r[4:1] == 4'd0);
        c.jmp_reg_flg = (r[8:5] == 4'd0);
        return c;
    endfunction

    function automatic exec_ctrl_t random_md_ctrl(input logic want_div);
        exec_ctrl_t  c;
        logic [31:0] r;
        r = next_rand();
        c.br_exe = BR_NONE;
        c.jmp_pc_flg = 1'b0;
        c.jmp_reg_flg = 1'b0;
        c.sign_sel = r[0] ? OP_UNSIGNED : OP_SIGNED;
        if (want_div) begin
            c.i_exe = r[1] ? ALU_REM : ALU_DIV;
        end else begin
            case (r[2:1])
                2'd0:    c.i_exe = ALU_MUL;
                2'd1:    c.i_exe = ALU_MULH;
                default: c.i_exe = ALU_MULHSU;
            endcase
        end
        return c;
    endfunction

    function automatic logic model_lt(input sign_sel_e s, input logic [31:0] a, b);
        if (s == OP_SIGNED) return $signed(a) < $signed(b);
        return a < b;
    endfunction

    function automatic logic [31:0] model_result(input exec_ctrl_t c, input logic [31:0] a, b);
        logic [63:0]        wide;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               sgn;
        sa = a;
        sb = b;
        sgn = (c.sign_sel == OP_SIGNED);
        case (c.i_exe)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA: begin
                wide = {{32{a[31]}}, a} >> b[4:0];
                return wide[31:0];
            end
            ALU_SLT:   return {31'b0, model_lt(c.sign_sel, a, b)};
            ALU_COPY2: return b;
            ALU_MUL: begin
                wide = {32'b0, a} * {32'b0, b};
                return wide[31:0];
            end
            ALU_MULH: begin
                if (sgn) wide = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                else wide = {32'b0, a} * {32'b0, b};
                return wide[63:32];
            end
            ALU_MULHSU: begin
                wide = {{32{a[31]}}, a} * {32'b0, b};  // Signed times unsigned
                return wide[63:32];
            end
            ALU_DIV: begin
                if (b == 32'd0) return 32'hffff_ffff;
                if (!sgn) return a / b;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return sa / sb;
            end
            ALU_REM: begin
                if (b == 32'd0) return a;
                if (!sgn) return a % b;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'd0;
                return sa % sb;
            end
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic model_taken(input exec_ctrl_t c, input logic v,
                                         input logic [31:0] a, b);
        logic cond;
        case (c.br_exe)
            BR_EQ:   cond = (a == b);
            BR_NE:   cond = (a != b);
            BR_LT:   cond = model_lt(c.sign_sel, a, b);
            BR_GE:   cond = !model_lt(c.sign_sel, a, b);
            default: cond = 1'b0;
        endcase
        return v & (c.jmp_pc_flg | c.jmp_reg_flg | cond);
    endfunction

    function automatic logic [31:0] model_target(input exec_ctrl_t c,
                                                 input logic [31:0] pc, a, b, ib, ij);
        logic [31:0] t;
        if (c.jmp_pc_flg) t = pc + ij;
        else if (c.jmp_reg_flg) t = a + b;
        else t = pc + ib;
        return t & ~32'd1;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp, act);
        checks = checks + 1;
        if (act !== exp) begin
            value_errors = value_errors + 1;
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, act);
        checks = checks + 1;
        if (act !== exp) begin
            flag_errors = flag_errors + 1;
            $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic drive_instr(input exec_ctrl_t c, input logic [31:0] a, b, pc, ib, ij);
        @(posedge clk);
        i_valid  <= 1'b1;
        i_is_new <= 1'b1;
        i_flush  <= 1'b0;
        i_ctrl   <= c;
        i_op1    <= a;
        i_op2    <= b;
        i_pc     <= pc;
        i_imm_b  <= ib;
        i_imm_j  <= ij;
    endtask

    task automatic random_alu_instr();
        exec_ctrl_t  c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] ib;
        logic [31:0] ij;
        c = random_ctrl(10);
        a = pick_operand();
        b = next_rand();
        b = (b[3:2] == 2'd0) ? a : pick_operand();  // Equal operands now and then
        pc = next_rand();
        ib = next_rand();
        ij = next_rand();
        drive_instr(c, a, b, pc, ib, ij);
        @(negedge clk);
        compare_value("o_next_alu_out", model_result(c, a, b), o_next_alu_out);
        compare_flag("o_is_stall", 1'b0, o_is_stall);
        compare_flag("o_branch_taken", model_taken(c, 1'b1, a, b), o_branch_taken);
        compare_value("o_branch_target", model_target(c, pc, a, b, ib, ij), o_branch_target);
    endtask

    task automatic idle_check();
        exec_ctrl_t  c;
        logic [31:0] a;
        logic [31:0] b;
        c = random_ctrl(15);
        a = pick_operand();
        b = pick_operand();
        @(posedge clk);
        i_valid  <= 1'b0;
        i_is_new <= a[0];
        i_ctrl   <= c;
        i_op1    <= a;
        i_op2    <= b;
        @(negedge clk);
        compare_flag("o_branch_taken", model_taken(c, 1'b0, a, b), o_branch_taken);
        compare_flag("o_is_stall", 1'b0, o_is_stall);
    endtask

    task automatic run_muldiv(input exec_ctrl_t c, input logic [31:0] a, b);
        logic [31:0] exp;
        exp = model_result(c, a, b);
        drive_instr(c, a, b, 32'd0, 32'd0, 32'd0);
        @(negedge clk);
        compare_flag("o_is_stall", 1'b1, o_is_stall);
        @(posedge clk);
        i_is_new <= 1'b0;
        @(negedge clk);
        while (o_is_stall) @(negedge clk);
        compare_value("o_next_alu_out", exp, o_next_alu_out);
        @(negedge clk);
        // Same instruction still held, saved result expected
        compare_flag("o_is_stall", 1'b0, o_is_stall);
        compare_value("o_next_alu_out", exp, o_next_alu_out);
    endtask

    task automatic flush_then_muldiv();
        logic [31:0] r;
        r = next_rand() % 24;
        drive_instr(random_md_ctrl(r[0]), pick_operand(), pick_operand(), 0, 0, 0);
        @(posedge clk);
        i_is_new <= 1'b0;
        repeat (r[4:0]) @(posedge clk);
        i_flush <= 1'b1;
        r = next_rand();
        run_muldiv(random_md_ctrl(r[0]), pick_operand(), pick_operand());
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units, the DUT appears to hang", WATCHDOG_TIME);
        $display("Test failures found");
        $finish;
    end

    initial begin
        exec_ctrl_t c;
        clk          = 1'b0;
        rng_state    = 32'h4126_98fc;
        checks       = 0;
        value_errors = 0;
        flag_errors  = 0;
        i_reset      = 1'b1;
        i_flush      = 1'b0;
        i_valid      = 1'b0;
        i_is_new     = 1'b0;
        i_pc         = '0;
        i_ctrl       = '0;
        i_imm_b      = '0;
        i_imm_j      = '0;
        i_op1        = '0;
        i_op2        = '0;
        repeat (5) @(posedge clk);
        i_reset <= 1'b0;

        repeat (N_ALU) random_alu_instr();
        repeat (N_IDLE) idle_check();
        repeat (N_MUL) run_muldiv(random_md_ctrl(1'b0), pick_operand(), pick_operand());
        repeat (N_DIV) run_muldiv(random_md_ctrl(1'b1), pick_operand(), pick_operand());

        // Divide by zero and signed overflow, DIV/REM in both signednesses
        for (int k = 0; k < N_FORCED; k++) begin
            c = random_md_ctrl(1'b1);
            c.i_exe = k[0] ? ALU_REM : ALU_DIV;
            c.sign_sel = k[1] ? OP_UNSIGNED : OP_SIGNED;
            if (k[2]) run_muldiv(c, pick_operand(), 32'd0);
            else run_muldiv(c, 32'h8000_0000, 32'hffff_ffff);
        end

        repeat (N_FLUSH) flush_then_muldiv();

        @(posedge clk);
        i_valid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("Checks: %0d, value errors: %0d, flag errors: %0d",
                 checks, value_errors, flag_errors);
        if (value_errors == 0 && flag_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
